// ==== Bender.yml ====
package:
  name: seg7_display

sources:
  # display RTL
  - include_dirs:
      - design
    files:
      - design/seg7_pkg.sv
      - design/digit_bus_if.sv
      - design/signed_bcd_converter.sv
      - design/scan_tick_gen.sv
      - design/digit_scanner.sv
      - design/seg7_display_top.sv

  # testbench and bound checker
  - target: test
    include_dirs:
      - design
    files:
      - dv/seg7_display_checker.sv
      - dv/seg7_display_tb.sv

// ==== design/digit_bus_if.sv ====
/*
  digit bus
  four digit codes plus a one-cycle update strobe,
  converter drives, scanner latches on the strobe
*/

`timescale 1ns/1ps

interface digit_bus_if import seg7_pkg::*; ();

  // codes for all positions, valid while upd is high
  digit_array_t digits;
  // single-cycle publish strobe, never back-pressured
  logic         upd;

  // converter side
  modport src (
    output digits,
    output upd
  );

  // scanner side
  modport dst (
    input  digits,
    input  upd
  );

endinterface

// ==== design/digit_scanner.sv ====
/*
  digit scanner
  holds the displayed codes, steps the active position on each
  scan tick and decodes that position onto shared segment lines
*/

`timescale 1ns/1ps

`include "seg7_defines.svh"

module digit_scanner import seg7_pkg::*; (
  input  logic     clk_1000hz,
  input  logic     rst_i,
  input  logic     tick_i,
  digit_bus_if.dst bus,
  output anode_t   an_o,
  output seg_t     seg_o
);

  localparam int unsigned POS_W = $clog2(`SEG7_NUM_DIGITS);
  // scan starts at the sign position
  localparam logic [POS_W-1:0] POS_TOP = POS_W'(`SEG7_NUM_DIGITS - 1);

  digit_array_t     digits_q;
  logic [POS_W-1:0] pos_q;
  digit_code_t      cur_code;

  // ------------------------------------------------------------
  // held digits
  // ------------------------------------------------------------

  // blank after reset so the display is dark
  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      digits_q <= {`SEG7_NUM_DIGITS{DIG_BLANK}};
    end else if (bus.upd) begin
      digits_q <= bus.digits;
    end
  end

  // ------------------------------------------------------------
  // position counter
  // ------------------------------------------------------------

  // counts down 3, 2, 1, 0 then wraps to 3
  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      pos_q <= POS_TOP;
    end else if (tick_i) begin
      pos_q <= pos_q - 1'b1;
    end
  end

  // one-hot active low, position 3 is the leftmost anode
  assign an_o = ~(anode_t'(1) << pos_q);

  // ------------------------------------------------------------
  // glyph decode
  // ------------------------------------------------------------

  assign cur_code = digits_q[pos_q];

  // {g, f, e, d, c, b, a}, zero lights
  always_comb begin
    case (cur_code)
      DIG_0:     seg_o = 7'b1000000;
      DIG_1:     seg_o = 7'b1111001;
      DIG_2:     seg_o = 7'b0100100;
      DIG_3:     seg_o = 7'b0110000;
      DIG_4:     seg_o = 7'b0011001;
      DIG_5:     seg_o = 7'b0010010;
      DIG_6:     seg_o = 7'b0000010;
      DIG_7:     seg_o = 7'b1111000;
      DIG_8:     seg_o = 7'b0000000;
      DIG_9:     seg_o = 7'b0010000;
      // middle bar only
      DIG_MINUS: seg_o = 7'b0111111;
      // blank and unused codes
      default:   seg_o = 7'b1111111;
    endcase
  end

endmodule

// ==== design/scan_tick_gen.sv ====
/*
  scan tick generator
  modulo counter on clk_1000hz, one enable pulse
  every SEG7_SCAN_DIV cycles
*/

`timescale 1ns/1ps

`include "seg7_defines.svh"

module scan_tick_gen (
  input  logic clk_1000hz,
  input  logic rst_i,
  output logic tick_o
);

  localparam int unsigned CNT_W = `SEG7_SCAN_CNT_W;
  // terminal count
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SEG7_SCAN_DIV - 1);

  logic [CNT_W-1:0] cnt_q;

  // wrap at CNT_LAST, tick registered on the wrap edge
  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (cnt_q == CNT_LAST) begin
      cnt_q  <= '0;
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q + 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

// ==== design/seg7_defines.svh ====
/*
  seven-segment display build constants
  position count and scan tick divisor shared by the
  package, the tick generator and the scanner
*/

`ifndef SEG7_DEFINES_SVH
`define SEG7_DEFINES_SVH

// ------------------------------------------------------------
// display geometry
// ------------------------------------------------------------

// sign position plus three decimal digits
`define SEG7_NUM_DIGITS 4

// ------------------------------------------------------------
// scan timing
// ------------------------------------------------------------

// clk_1000hz cycles per scan tick, any value of 1 or more
`define SEG7_SCAN_DIV 4
// tick counter width, large enough to hold SEG7_SCAN_DIV
`define SEG7_SCAN_CNT_W ($clog2((`SEG7_SCAN_DIV) + 1))

`endif

// ==== design/seg7_display_top.sv ====
/*
  seven-segment display top
  signed 8-bit value in by valid/ready, four multiplexed
  common-anode digits out on active-low anode and segment lines
*/

`timescale 1ns/1ps

module seg7_display_top import seg7_pkg::*; (
  input  logic              clk_1000hz,
  input  logic              rst_i,
  input  logic signed [7:0] value_i,
  input  logic              value_valid_i,
  output logic              value_ready_o,
  output anode_t            an_o,
  output seg_t              seg_o
);

  // converter to scanner
  digit_bus_if bus_if ();

  // scan enable pulse
  logic scan_tick;

  signed_bcd_converter conv_i (
    .clk_1000hz    (clk_1000hz),
    .rst_i         (rst_i),
    .value_i       (value_i),
    .value_valid_i (value_valid_i),
    .value_ready_o (value_ready_o),
    .bus           (bus_if.src)
  );

  scan_tick_gen tick_i (
    .clk_1000hz (clk_1000hz),
    .rst_i      (rst_i),
    .tick_o     (scan_tick)
  );

  digit_scanner scan_i (
    .clk_1000hz (clk_1000hz),
    .rst_i      (rst_i),
    .tick_i     (scan_tick),
    .bus        (bus_if.dst),
    .an_o       (an_o),
    .seg_o      (seg_o)
  );

endmodule

// ==== design/seg7_pkg.sv ====
/*
  seven-segment display types
  digit codes, segment patterns, anode select and the
  digit array passed from converter to scanner
*/

`include "seg7_defines.svh"

package seg7_pkg;

  // ------------------------------------------------------------
  // digit codes
  // ------------------------------------------------------------

  // numerals keep their binary value, glyphs sit above 9
  typedef enum logic [3:0] {
    DIG_0     = 4'd0,
    DIG_1     = 4'd1,
    DIG_2     = 4'd2,
    DIG_3     = 4'd3,
    DIG_4     = 4'd4,
    DIG_5     = 4'd5,
    DIG_6     = 4'd6,
    DIG_7     = 4'd7,
    DIG_8     = 4'd8,
    DIG_9     = 4'd9,
    DIG_MINUS = 4'd10,
    DIG_BLANK = 4'd15
  } digit_code_t;

  // {g, f, e, d, c, b, a}, a zero lights the segment
  typedef logic [6:0] seg_t;

  // one bit per position, a zero enables that digit
  typedef logic [`SEG7_NUM_DIGITS-1:0] anode_t;

  // index 0 is units, top index is the sign position
  typedef digit_code_t [`SEG7_NUM_DIGITS-1:0] digit_array_t;

endpackage

// ==== design/signed_bcd_converter.sv ====
/*
  signed value to display digits
  accepts an 8-bit signed value over valid/ready, counts hundreds
  and tens by repeated subtraction, then publishes sign and digits
  with leading zeros blanked through a one-cycle strobe
*/

`timescale 1ns/1ps

module signed_bcd_converter import seg7_pkg::*; (
  input  logic              clk_1000hz,
  input  logic              rst_i,
  input  logic signed [7:0] value_i,
  input  logic              value_valid_i,
  output logic              value_ready_o,
  digit_bus_if.src          bus
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_HUND = 2'd1,
    ST_TENS = 2'd2
  } conv_state_t;

  conv_state_t state_q;

  // working remainder and digit counters
  logic [7:0]  rem_q;
  logic [3:0]  hund_q;
  logic [3:0]  tens_q;
  digit_code_t sign_q;

  logic        take;
  logic        sub_h;
  logic        sub_t;
  logic        done;
  logic [7:0]  mag_in;
  digit_code_t hund_code;
  digit_code_t tens_code;
  digit_code_t unit_code;

  // ------------------------------------------------------------
  // step decisions
  // ------------------------------------------------------------

  always_comb begin
    take  = value_valid_i && value_ready_o;
    // hundreds first, only while in the hundreds phase
    sub_h = (state_q == ST_HUND) && (rem_q >= 8'd100);
    // tens once hundreds are exhausted, may start from ST_HUND
    sub_t = (state_q != ST_IDLE) && !sub_h && (rem_q >= 8'd10);
    // remainder under ten is the units digit
    done  = (state_q != ST_IDLE) && (rem_q < 8'd10);
  end

  // magnitude, -128 wraps to 8'h80 which reads as 128 unsigned
  assign mag_in = value_i[7] ? 8'(-value_i) : 8'(value_i);

  // leading zero blanking
  always_comb begin
    hund_code = (hund_q == 4'd0) ? DIG_BLANK : digit_code_t'(hund_q);
    if ((hund_q == 4'd0) && (tens_q == 4'd0)) begin
      tens_code = DIG_BLANK;
    end else begin
      tens_code = digit_code_t'(tens_q);
    end
    unit_code = digit_code_t'(rem_q[3:0]);
  end

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      state_q       <= ST_IDLE;
      value_ready_o <= 1'b1;
      bus.upd       <= 1'b0;
    end else begin
      // strobe lasts one cycle
      bus.upd <= done;
      if (take) begin
        state_q       <= ST_HUND;
        value_ready_o <= 1'b0;
      end else if (done) begin
        // ready comes back together with the strobe
        state_q       <= ST_IDLE;
        value_ready_o <= 1'b1;
      end else if (sub_t) begin
        state_q <= ST_TENS;
      end
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  always_ff @(posedge clk_1000hz) begin
    if (take) begin
      rem_q  <= mag_in;
      hund_q <= 4'd0;
      tens_q <= 4'd0;
      sign_q <= value_i[7] ? DIG_MINUS : DIG_BLANK;
    end else if (sub_h) begin
      rem_q  <= rem_q - 8'd100;
      hund_q <= hund_q + 4'd1;
    end else if (sub_t) begin
      rem_q  <= rem_q - 8'd10;
      tens_q <= tens_q + 4'd1;
    end
    // publish alongside the strobe
    if (done) begin
      bus.digits[3] <= sign_q;
      bus.digits[2] <= hund_code;
      bus.digits[1] <= tens_code;
      bus.digits[0] <= unit_code;
    end
  end

endmodule

// ==== dv/seg7_display_checker.sv ====
/*
  display protocol checker
  bound to the display top, watches the anode select, the host
  handshake and the segment lines for illegal patterns
*/

`timescale 1ns/1ps

module seg7_display_checker import seg7_pkg::*; (
  input logic              clk_1000hz,
  input logic              rst_i,
  input logic signed [7:0] value_i,
  input logic              value_valid_i,
  input logic              value_ready_o,
  input anode_t            an_o,
  input seg_t              seg_o
);

  // failure counts per property
  int unsigned err_anode = 0;
  int unsigned err_hold  = 0;
  int unsigned err_seg   = 0;
  // total, watched from the testbench
  int unsigned err_cnt;

  assign err_cnt = err_anode + err_hold + err_seg;

  // ------------------------------------------------------------
  // properties
  // ------------------------------------------------------------

  // exactly one digit enabled at any time
  one_anode_a: assert property (@(posedge clk_1000hz) disable iff (!rst_i)
    $countones(~an_o) == 1)
  else begin
    err_anode = err_anode + 1;
    $error("an_o does not enable exactly one digit");
  end

  // host keeps its offer while the converter is busy
  hold_value_a: assert property (@(posedge clk_1000hz) disable iff (!rst_i)
    (value_valid_i && !value_ready_o) |=> (value_valid_i && $stable(value_i)))
  else begin
    err_hold = err_hold + 1;
    $error("value_i or value_valid_i changed under back-pressure");
  end

  // numerals 0 to 9, minus and blank only
  seg_legal_a: assert property (@(posedge clk_1000hz) disable iff (!rst_i)
    seg_o inside {7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
                  7'h02, 7'h78, 7'h00, 7'h10, 7'h3f, 7'h7f})
  else begin
    err_seg = err_seg + 1;
    $error("seg_o shows a pattern outside the glyph table");
  end

endmodule

// ==== dv/seg7_display_tb.sv ====
/*
  seven-segment display testbench
  directed tests of reset state, fixed and random values and back-pressure
  scanned glyphs compared with a digit model
*/

`timescale 1ns/1ps

`include "seg7_defines.svh"

module seg7_display_tb import seg7_pkg::*; ();

  localparam int  NUM_POS    = `SEG7_NUM_DIGITS;
  localparam int  WAIT_LIMIT = 200;
  // two full rotations plus slack
  localparam int  OBS_LIMIT  = 2 * NUM_POS * `SEG7_SCAN_DIV + 8;
  localparam time DRIVE_DLY  = 1ns;

  logic              clk_1000hz;
  logic              rst_i;
  logic signed [7:0] value_i;
  logic              value_valid_i;
  logic              value_ready_o;
  anode_t            an_o;
  seg_t              seg_o;

  // last sample per scan position
  seg_t seen_seg [NUM_POS];
  bit   seen     [NUM_POS];

  seg7_display_top dut_i (
    .clk_1000hz    (clk_1000hz),
    .rst_i         (rst_i),
    .value_i       (value_i),
    .value_valid_i (value_valid_i),
    .value_ready_o (value_ready_o),
    .an_o          (an_o),
    .seg_o         (seg_o)
  );

  bind seg7_display_top seg7_display_checker chk_i (
    .clk_1000hz    (clk_1000hz),
    .rst_i         (rst_i),
    .value_i       (value_i),
    .value_valid_i (value_valid_i),
    .value_ready_o (value_ready_o),
    .an_o          (an_o),
    .seg_o         (seg_o)
  );

  initial begin
    clk_1000hz = 1'b0;
    forever #5 clk_1000hz = ~clk_1000hz;
  end

  // ------------------------------------------------------------
  // failure reporting and compare tasks
  // ------------------------------------------------------------

  task automatic stop_on_error();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_seg(input string name, input seg_t got, input seg_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_anode(input string name, input anode_t got, input anode_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  always @(posedge clk_1000hz) begin
    if (dut_i.chk_i.err_cnt != 0) begin
      $display("an assertion in the bound checker failed");
      stop_on_error();
    end
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // gfedcba active low with -1 as blank and 10 as minus
  function automatic seg_t glyph_pattern(input int code);
    case (code)
      0:       return 7'h40;
      1:       return 7'h79;
      2:       return 7'h24;
      3:       return 7'h30;
      4:       return 7'h19;
      5:       return 7'h12;
      6:       return 7'h02;
      7:       return 7'h78;
      8:       return 7'h00;
      9:       return 7'h10;
      10:      return 7'h3f;
      default: return 7'h7f;
    endcase
  endfunction

  // glyph at one position where 3 is the sign
  function automatic seg_t expected_glyph(input int value, input int pos);
    int mag;
    int hund;
    int tens;
    int code;
    mag  = (value < 0) ? -value : value;
    hund = mag / 100;
    tens = (mag / 10) % 10;
    case (pos)
      3:       code = (value < 0) ? 10 : -1;
      2:       code = (hund == 0) ? -1 : hund;
      1:       code = (hund == 0 && tens == 0) ? -1 : tens;
      default: code = mag % 10;
    endcase
    return glyph_pattern(code);
  endfunction

  // one cycle per subtraction plus the publish cycle
  function automatic int conv_cycles(input int value);
    int mag;
    mag = (value < 0) ? -value : value;
    return mag / 100 + (mag % 100) / 10 + 1;
  endfunction

  function automatic anode_t anode_for(input int pos);
    case (pos)
      3:       return 4'b0111;
      2:       return 4'b1011;
      1:       return 4'b1101;
      default: return 4'b1110;
    endcase
  endfunction

  function automatic int anode_index(input anode_t an);
    int p;
    for (p = 0; p < NUM_POS; p++) begin
      if (an === anode_for(p)) begin
        return p;
      end
    end
    return -1;
  endfunction

  // ------------------------------------------------------------
  // handshake and observation
  // ------------------------------------------------------------

  // returns the number of cycles ready was seen low
  task automatic wait_ready_high(input string what, output int cycles);
    cycles = 0;
    while (value_ready_o !== 1'b1) begin
      if (cycles >= WAIT_LIMIT) begin
        $display("value_ready_o stayed low for %0d cycles while %s", WAIT_LIMIT, what);
        stop_on_error();
      end
      @(posedge clk_1000hz);
      #DRIVE_DLY;
      cycles++;
    end
  endtask

  task automatic check_latency(input int busy, input int value);
    if (busy != conv_cycles(value)) begin
      $display("Mismatch value_ready_o low cycles for %0d: got 0x%h, expected 0x%h",
               value, busy, conv_cycles(value));
      stop_on_error();
    end
  endtask

  task automatic send_value(input logic signed [7:0] v);
    int busy;
    value_i       = v;
    value_valid_i = 1'b1;
    wait_ready_high("offering a value", busy);
    // transfer on this edge
    @(posedge clk_1000hz);
    #DRIVE_DLY;
    value_valid_i = 1'b0;
    check_flag("value_ready_o", value_ready_o, 1'b0);
    wait_ready_high("converting", busy);
    check_latency(busy, int'(v));
  endtask

  // one segment sample per anode position with the scan order checked
  task automatic observe_positions();
    int cycles;
    int pos;
    int prev_pos;
    int p;
    for (p = 0; p < NUM_POS; p++) begin
      seen[p] = 1'b0;
    end
    prev_pos = -1;
    cycles   = 0;
    while (!(seen[0] && seen[1] && seen[2] && seen[3])) begin
      if (cycles >= OBS_LIMIT) begin
        $display("scan did not reach every anode position within %0d cycles", OBS_LIMIT);
        stop_on_error();
      end
      @(posedge clk_1000hz);
      #DRIVE_DLY;
      cycles++;
      pos = anode_index(an_o);
      if (pos < 0) begin
        $display("Mismatch an_o: got 0x%h, expected a single low bit", an_o);
        stop_on_error();
      end
      // scan steps downward and wraps from 0 to 3
      if (prev_pos >= 0 && pos != prev_pos) begin
        check_anode("an_o", an_o, anode_for((prev_pos + NUM_POS - 1) % NUM_POS));
      end
      seen_seg[pos] = seg_o;
      seen[pos]     = 1'b1;
      prev_pos      = pos;
    end
  endtask

  task automatic check_display(input int value);
    int p;
    observe_positions();
    for (p = 0; p < NUM_POS; p++) begin
      check_seg($sformatf("seg_o at position %0d", p), seen_seg[p], expected_glyph(value, p));
    end
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------

  task automatic test_reset_state();
    int p;
    check_flag("value_ready_o", value_ready_o, 1'b1);
    check_anode("an_o", an_o, anode_for(3));
    check_seg("seg_o", seg_o, 7'h7f);
    observe_positions();
    for (p = 0; p < NUM_POS; p++) begin
      check_seg($sformatf("seg_o at position %0d", p), seen_seg[p], 7'h7f);
    end
  endtask

  task automatic test_value(input logic signed [7:0] v);
    send_value(v);
    check_display(int'(v));
  endtask

  // second offer held while the first value converts
  task automatic test_back_pressure();
    int busy;
    logic signed [7:0] first_v;
    logic signed [7:0] second_v;
    first_v       = 8'sd99;
    second_v      = -8'sd56;
    value_i       = first_v;
    value_valid_i = 1'b1;
    wait_ready_high("offering the first value", busy);
    @(posedge clk_1000hz);
    #DRIVE_DLY;
    value_i = second_v;
    wait_ready_high("holding the second value", busy);
    check_latency(busy, int'(first_v));
    @(posedge clk_1000hz);
    #DRIVE_DLY;
    value_valid_i = 1'b0;
    check_flag("value_ready_o", value_ready_o, 1'b0);
    wait_ready_high("converting the second value", busy);
    check_latency(busy, int'(second_v));
    // no extra transfer once valid is low
    repeat (4) begin
      @(posedge clk_1000hz);
      #DRIVE_DLY;
      check_flag("value_ready_o", value_ready_o, 1'b1);
    end
    check_display(int'(second_v));
  endtask

  initial begin
    logic [31:0] rnd;
    int i;
    rnd           = $urandom(32'hd5dc_d462);
    rst_i         = 1'b0;
    value_i       = '0;
    value_valid_i = 1'b0;
    repeat (3) @(posedge clk_1000hz);
    #DRIVE_DLY;
    rst_i = 1'b1;
    test_reset_state();
    test_value(8'sd0);
    test_value(8'sd7);
    test_value(8'sd42);
    test_value(8'sd127);
    test_value(-8'sd1);
    test_value(-8'sd10);
    // most negative value -128
    test_value(8'sh80);
    test_back_pressure();
    for (i = 0; i < 20; i++) begin
      rnd = $urandom;
      test_value(rnd[7:0]);
    end
    if (dut_i.chk_i.err_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

// ==== vlog.f ====
+incdir+design
design/seg7_pkg.sv
design/digit_bus_if.sv
design/signed_bcd_converter.sv
design/scan_tick_gen.sv
design/digit_scanner.sv
design/seg7_display_top.sv
dv/seg7_display_checker.sv
dv/seg7_display_tb.sv
